/* tb.f */
+incdir+rtl
rtl/soc_bus_pkg.sv
rtl/clint_timer.sv
rtl/axi_sram.sv
rtl/bus_arbiter.sv
rtl/soc_bus_top.sv
bench/tb_soc_bus.sv

/* bench/soc_bus_cases.txt */
# op addr strb data expect, all hex, op F fetch L load S store A all three T timer twice
# store data sits in the low bits, expect is the zero-extended load result or console byte
S 00000100 0f 11223344 00000000
L 00000100 0f 00000000 11223344
F 00000100 0f 00000000 11223344
S 00000104 0f a5a55a5a 00000000
L 00000104 0f 00000000 a5a55a5a
F 00000104 0f 00000000 a5a55a5a
L 00000100 0f 00000000 11223344
S 00000108 0f 00000000 00000000
S 00000109 01 000000ab 00000000
S 0000010b 01 000000cd 00000000
S 00000108 01 000000ef 00000000
S 0000010a 01 00000077 00000000
L 00000108 0f 00000000 cd77abef
S 0000010c 0f ffffffff 00000000
S 0000010c 03 00001234 00000000
S 0000010e 03 00005678 00000000
L 0000010c 0f 00000000 56781234
L 00000100 01 00000000 00000044
L 00000101 01 00000000 00000033
L 00000102 01 00000000 00000022
L 00000103 01 00000000 00000011
L 00000100 03 00000000 00003344
L 00000102 03 00000000 00001122
L 00000106 01 00000000 000000a5
L 00000104 03 00000000 00005a5a
L 00000106 03 00000000 0000a5a5
A 00000110 0f cafef00d cafef00d
T a0000048 0f 00000000 00000000
L a000004c 0f 00000000 00000000
S a00003f8 01 00000041 00000041
L 00000100 0f 00000000 11223344
L 00000108 0f 00000000 cd77abef

/* bench/tb_soc_bus.sv */
`timescale 1ns/1ps
`include "soc_bus_cfg.svh"

module tb_soc_bus
  import soc_bus_pkg::*;
();

  localparam int MAX_CASES = 64;

  logic     clk;
  logic     rst;
  rd_req_t  fetch_i;
  rd_resp_t fetch_o;
  ld_req_t  load_i;
  rd_resp_t load_o;
  st_req_t  store_i;
  logic     store_ready_o;
  console_t console_o;

  // case table filled from the file before reset ends
  logic [7:0]  op_m   [MAX_CASES];
  logic [31:0] addr_m [MAX_CASES];
  logic [7:0]  strb_m [MAX_CASES];
  logic [31:0] data_m [MAX_CASES];
  logic [31:0] exp_m  [MAX_CASES];
  int          n_cases;

  // what the last transaction returned
  logic [31:0] ld_data;
  logic [31:0] f_data;
  logic [23:0] order;
  logic        cons_seen;
  logic [7:0]  cons_ch;

  int     errors;
  int     checks;
  int     cycles;
  int     limit;
  integer seed;

  soc_bus_top UUT (
    .clk           (clk),
    .rst           (rst),
    .fetch_i       (fetch_i),
    .fetch_o       (fetch_o),
    .load_i        (load_i),
    .load_o        (load_o),
    .store_i       (store_i),
    .store_ready_o (store_ready_o),
    .console_o     (console_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // run limit armed once the case count is known
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit)
    begin
      $display("timeout: no response after %0d cycles", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic read_cases();
    integer      fd;
    integer      rc;
    logic [63:0] tok;
    logic [8*128-1:0] line;
    logic [31:0] a;
    logic [31:0] s;
    logic [31:0] d;
    logic [31:0] e;
    begin
      n_cases = 0;
      fd = $fopen("bench/soc_bus_cases.txt", "r");
      if (fd == 0)
      begin
        $display("cannot open bench/soc_bus_cases.txt");
        errors++;
      end
      else
      begin
        while (!$feof(fd) && n_cases < MAX_CASES)
        begin
          rc = $fscanf(fd, "%s", tok);
          if (rc == 1)
          begin
            // a lone # starts a comment line
            if (tok[7:0] == "#")
              rc = $fgets(line, fd);
            else
            begin
              rc = $fscanf(fd, "%h %h %h %h", a, s, d, e);
              if (rc != 4)
              begin
                $display("case line %0d is incomplete", n_cases);
                errors++;
              end
              op_m[n_cases]   = tok[7:0];
              addr_m[n_cases] = a;
              strb_m[n_cases] = s[7:0];
              data_m[n_cases] = d;
              exp_m[n_cases]  = e;
              n_cases++;
            end
          end
        end
        $fclose(fd);
      end
    end
  endtask

  // raise the masked levels, drop each one after its own pulse
  // mask bits are store, load, fetch from the top
  task automatic run_txn(input logic [2:0] mask, input logic [31:0] addr,
                         input logic [7:0] strb, input logic [31:0] data);
    logic [2:0] pend;
    begin
      pend      = mask;
      order     = '0;
      cons_seen = 1'b0;
      cons_ch   = '0;
      store_i.addr   = addr;
      store_i.data   = data;
      store_i.strb   = strb;
      store_i.valid  = mask[2];
      load_i.rd.addr = addr;
      load_i.strb    = strb;
      load_i.rd.valid = mask[1];
      fetch_i.addr   = addr;
      fetch_i.valid  = mask[0];
      while (pend != 3'b000)
      begin
        // outputs settle well before the falling edge
        @(negedge clk);
        if (store_ready_o)
        begin
          pend[2] = 1'b0;
          order   = {order[15:0], "S"};
        end
        if (load_o.valid)
        begin
          pend[1] = 1'b0;
          order   = {order[15:0], "L"};
          ld_data = load_o.data;
        end
        if (fetch_o.valid)
        begin
          pend[0] = 1'b0;
          order   = {order[15:0], "F"};
          f_data  = fetch_o.data;
        end
        if (console_o.valid)
        begin
          cons_seen = 1'b1;
          cons_ch   = console_o.ch;
        end
        @(posedge clk);
        #1;
        store_i.valid   = pend[2];
        load_i.rd.valid = pend[1];
        fetch_i.valid   = pend[0];
      end
    end
  endtask

  task automatic idle_gap();
    int gap;
    begin
      gap = 1 + ($unsigned($random(seed)) % 4);
      repeat (gap) @(posedge clk);
      #1;
    end
  endtask

  initial
  begin
    logic [31:0] t0;
    rst     = 1'b1;
    fetch_i = '0;
    load_i  = '0;
    store_i = '0;
    errors  = 0;
    checks  = 0;
    cycles  = 0;
    limit   = 0;
    seed    = 96292;
    ld_data = '0;
    f_data  = '0;
    read_cases();
    limit = 200 * (n_cases + 1);
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    idle_gap();
    for (int i = 0; i < n_cases; i++)
    begin
      case (op_m[i])
        "S":
        begin
          run_txn(3'b100, addr_m[i], strb_m[i], data_m[i]);
          checks++;
          if (addr_m[i] == `SOC_SERIAL_ADDR)
          begin
            assert (cons_seen)
            else
            begin
              $display("no console pulse for the serial store in case %0d", i);
              errors++;
            end
            assert (cons_ch === exp_m[i][7:0])
            else
            begin
              $display("MISMATCH console_o.ch case %0d: got %h expected %h",
                       i, cons_ch, exp_m[i][7:0]);
              errors++;
            end
          end
          else
            assert (!cons_seen)
            else
            begin
              $display("console pulse on a memory store in case %0d", i);
              errors++;
            end
        end
        "L":
        begin
          run_txn(3'b010, addr_m[i], strb_m[i], data_m[i]);
          checks++;
          assert (ld_data === exp_m[i])
          else
          begin
            $display("MISMATCH load_o.data case %0d addr %h: got %h expected %h",
                     i, addr_m[i], ld_data, exp_m[i]);
            errors++;
          end
        end
        "F":
        begin
          run_txn(3'b001, addr_m[i], 8'h0f, data_m[i]);
          checks++;
          assert (f_data === exp_m[i])
          else
          begin
            $display("MISMATCH fetch_o.data case %0d addr %h: got %h expected %h",
                     i, addr_m[i], f_data, exp_m[i]);
            errors++;
          end
        end
        "A":
        begin
          // store wins, so the load and fetch see the new data
          run_txn(3'b111, addr_m[i], strb_m[i], data_m[i]);
          checks += 3;
          assert (order === "SLF")
          else
          begin
            $display("responses came in the wrong order in case %0d: %s", i, order);
            errors++;
          end
          assert (ld_data === exp_m[i])
          else
          begin
            $display("MISMATCH load_o.data case %0d: got %h expected %h",
                     i, ld_data, exp_m[i]);
            errors++;
          end
          assert (f_data === exp_m[i])
          else
          begin
            $display("MISMATCH fetch_o.data case %0d: got %h expected %h",
                     i, f_data, exp_m[i]);
            errors++;
          end
        end
        "T":
        begin
          run_txn(3'b010, addr_m[i], strb_m[i], 32'h0);
          t0 = ld_data;
          idle_gap();
          run_txn(3'b010, addr_m[i], strb_m[i], 32'h0);
          checks++;
          assert (!$isunknown(t0) && !$isunknown(ld_data) && ld_data > t0)
          else
          begin
            $display("timer low half did not advance: first %h second %h", t0, ld_data);
            errors++;
          end
        end
        default:
        begin
          $display("unknown op in case %0d", i);
          errors++;
        end
      endcase
      idle_gap();
    end
    if (n_cases == 0)
    begin
      $display("the case file holds no cases");
      errors++;
    end
    $display("errors: %0d in %0d checks over %0d cases", errors, checks, n_cases);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* rtl/soc_bus_top.sv */
`timescale 1ns/1ps
`include "soc_bus_cfg.svh"

module soc_bus_top
  import soc_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  rd_req_t  fetch_i,
  output rd_resp_t fetch_o,
  input  ld_req_t  load_i,
  output rd_resp_t load_o,
  input  st_req_t  store_i,
  output logic     store_ready_o,
  output console_t console_o
);

  // axi between arbiter and sram
  axi_ar_t ar;
  logic    ar_ready;
  axi_aw_t aw;
  logic    aw_ready;
  axi_w_t  w;
  logic    w_ready;
  axi_r_t  r;
  axi_b_t  b;

  // timer side band
  logic                   timer_rd;
  logic                   timer_hi;
  logic [`SOC_DATA_W-1:0] timer_data;
  logic                   timer_valid;

  bus_arbiter u_arbiter (
    .clk           (clk),
    .rst           (rst),
    .fetch_i       (fetch_i),
    .fetch_o       (fetch_o),
    .load_i        (load_i),
    .load_o        (load_o),
    .store_i       (store_i),
    .store_ready_o (store_ready_o),
    .ar_o          (ar),
    .ar_ready_i    (ar_ready),
    .aw_o          (aw),
    .aw_ready_i    (aw_ready),
    .w_o           (w),
    .w_ready_i     (w_ready),
    .r_i           (r),
    .b_i           (b),
    .timer_rd_o    (timer_rd),
    .timer_hi_o    (timer_hi),
    .timer_data_i  (timer_data),
    .timer_valid_i (timer_valid),
    .console_o     (console_o)
  );

  clint_timer u_timer (
    .clk     (clk),
    .rst     (rst),
    .rd_i    (timer_rd),
    .hi_i    (timer_hi),
    .data_o  (timer_data),
    .valid_o (timer_valid)
  );

  axi_sram u_sram (
    .clk        (clk),
    .rst        (rst),
    .ar_i       (ar),
    .ar_ready_o (ar_ready),
    .aw_i       (aw),
    .aw_ready_o (aw_ready),
    .w_i        (w),
    .w_ready_o  (w_ready),
    .r_o        (r),
    .b_o        (b)
  );

endmodule

/* rtl/bus_arbiter.sv */
`timescale 1ns/1ps
`include "soc_bus_cfg.svh"

module bus_arbiter
  import soc_bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  rd_req_t                fetch_i,
  output rd_resp_t               fetch_o,
  input  ld_req_t                load_i,
  output rd_resp_t               load_o,
  input  st_req_t                store_i,
  output logic                   store_ready_o,
  output axi_ar_t                ar_o,
  input  logic                   ar_ready_i,
  output axi_aw_t                aw_o,
  input  logic                   aw_ready_i,
  output axi_w_t                 w_o,
  input  logic                   w_ready_i,
  input  axi_r_t                 r_i,
  input  axi_b_t                 b_i,
  output logic                   timer_rd_o,
  output logic                   timer_hi_o,
  input  logic [`SOC_DATA_W-1:0] timer_data_i,
  input  logic                   timer_valid_i,
  output console_t               console_o
);

  // loc states serve timer loads and console stores without the bus
  typedef enum logic [2:0] {
    S_IDLE,
    S_LOC_REQ,
    S_LOC_RSP,
    S_AR,
    S_R,
    S_AW,
    S_B
  } state_t;

  typedef enum logic [1:0] {
    K_FETCH,
    K_LOAD,
    K_STORE
  } kind_t;

  state_t                 state_q;
  state_t                 state_d;
  kind_t                  kind_q;
  kind_t                  sel_kind;
  logic                   sel_any;
  logic                   sel_local;
  logic [`SOC_ADDR_W-1:0] sel_addr;
  logic [7:0]             sel_strb;
  logic [`SOC_ADDR_W-1:0] addr_q;
  logic [`SOC_DATA_W-1:0] data_q;
  logic [7:0]             strb_q;
  logic [1:0]             off;
  logic [2:0]             ax_size;
  logic [`SOC_DATA_W-1:0] wr_shift;
  logic [3:0]             wr_strb4;
  logic [`SOC_DATA_W-1:0] rd_word;
  logic [`SOC_DATA_W-1:0] rd_shift;
  logic [`SOC_DATA_W-1:0] rd_mask;
  logic [`SOC_DATA_W-1:0] rd_data;
  logic                   rd_done;
  logic                   loc_done;

  // fixed priority: store, then load, then fetch
  always_comb
  begin
    sel_any  = 1'b1;
    sel_kind = K_FETCH;
    sel_addr = fetch_i.addr;
    // fetch is always a full word
    sel_strb = 8'h0f;
    if (store_i.valid)
    begin
      sel_kind = K_STORE;
      sel_addr = store_i.addr;
      sel_strb = store_i.strb;
    end
    else if (load_i.rd.valid)
    begin
      sel_kind = K_LOAD;
      sel_addr = load_i.rd.addr;
      sel_strb = load_i.strb;
    end
    else if (!fetch_i.valid)
      sel_any = 1'b0;
  end

  // timer only answers loads, console only takes stores
  always_comb
  begin
    sel_local = 1'b0;
    if (sel_kind == K_STORE)
      sel_local = (sel_addr == `SOC_SERIAL_ADDR);
    else if (sel_kind == K_LOAD)
      sel_local = (sel_addr == `SOC_RTC_ADDR) || (sel_addr == `SOC_RTC_ADDR_UP);
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE:
        if (sel_any)
        begin
          if (sel_local)
            state_d = S_LOC_REQ;
          else if (sel_kind == K_STORE)
            state_d = S_AW;
          else
            state_d = S_AR;
        end
      S_LOC_REQ:
        state_d = S_LOC_RSP;
      S_LOC_RSP:
        state_d = S_IDLE;
      S_AR:
        if (ar_ready_i)
          state_d = S_R;
      S_R:
        if (r_i.valid)
          state_d = S_IDLE;
      S_AW:
        if (aw_ready_i && w_ready_i)
          state_d = S_B;
      S_B:
        if (b_i.valid)
          state_d = S_IDLE;
      default:
        state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= S_IDLE;
      kind_q  <= K_FETCH;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == S_IDLE && sel_any)
        kind_q <= sel_kind;
    end
  end

  // request fields captured once, stay put for the whole transaction
  always_ff @(posedge clk)
  begin
    if (state_q == S_IDLE && sel_any)
    begin
      addr_q <= sel_addr;
      data_q <= store_i.data;
      strb_q <= sel_strb;
    end
  end

  assign off = addr_q[1:0];

  // axi size from the strobe pattern
  always_comb
  begin
    case (strb_q)
      8'h01:   ax_size = 3'd0;
      8'h03:   ax_size = 3'd1;
      default: ax_size = 3'd2;
    endcase
  end

  always_comb
  begin
    ar_o.addr  = addr_q;
    ar_o.size  = ax_size;
    ar_o.valid = (state_q == S_AR);
    aw_o.addr  = addr_q;
    aw_o.size  = ax_size;
    aw_o.valid = (state_q == S_AW);
  end

  // write lanes: data shifted up by the byte offset, copied to both words
  assign wr_shift = data_q << {off, 3'b000};
  assign wr_strb4 = strb_q[3:0] << off;

  always_comb
  begin
    w_o.data.w[0] = wr_shift;
    w_o.data.w[1] = wr_shift;
    // bit 2 picks which half of the beat is enabled
    w_o.strb  = addr_q[2] ? {wr_strb4, 4'h0} : {4'h0, wr_strb4};
    w_o.last  = 1'b1;
    w_o.valid = (state_q == S_AW);
  end

  // read lanes: pick word, shift down, zero the bytes outside the strobe
  assign rd_word  = (state_q == S_LOC_RSP) ? timer_data_i :
                    addr_q[2] ? r_i.data.w[1] : r_i.data.w[0];
  assign rd_shift = rd_word >> {off, 3'b000};
  assign rd_mask  = {{8{strb_q[3]}}, {8{strb_q[2]}}, {8{strb_q[1]}}, {8{strb_q[0]}}};
  assign rd_data  = rd_shift & rd_mask;

  // rready and bready are tied high, so r or b ends the transaction
  assign rd_done  = (state_q == S_R) && r_i.valid;
  assign loc_done = (state_q == S_LOC_RSP);

  always_comb
  begin
    fetch_o.data  = rd_data;
    fetch_o.valid = rd_done && (kind_q == K_FETCH);
    load_o.data   = rd_data;
    load_o.valid  = (rd_done || (loc_done && timer_valid_i)) && (kind_q == K_LOAD);
  end

  assign store_ready_o = ((state_q == S_B) && b_i.valid) ||
                         (loc_done && (kind_q == K_STORE));

  // timer read strobe lasts one cycle, data comes back in loc_rsp
  assign timer_rd_o = (state_q == S_LOC_REQ) && (kind_q == K_LOAD);
  assign timer_hi_o = (addr_q == `SOC_RTC_ADDR_UP);

  // console byte goes out with the store ready pulse
  always_comb
  begin
    console_o.ch    = data_q[7:0];
    console_o.valid = loc_done && (kind_q == K_STORE);
  end

  // one transaction in flight, so never two answers at once
  a_one_resp: assert property (@(posedge clk) disable iff (rst)
    $onehot0({fetch_o.valid, load_o.valid, store_ready_o}));

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    ar_o.valid && !ar_ready_i |=> ar_o.valid && $stable(ar_o.addr));

  // the sram never reports errors
  a_r_okay: assert property (@(posedge clk) disable iff (rst)
    r_i.valid |-> r_i.resp == 2'b00);

  a_b_okay: assert property (@(posedge clk) disable iff (rst)
    b_i.valid |-> b_i.resp == 2'b00);

endmodule

/* rtl/axi_sram.sv */
`timescale 1ns/1ps
`include "soc_bus_cfg.svh"

module axi_sram
  import soc_bus_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  axi_ar_t ar_i,
  output logic    ar_ready_o,
  input  axi_aw_t aw_i,
  output logic    aw_ready_o,
  input  axi_w_t  w_i,
  output logic    w_ready_o,
  output axi_r_t  r_o,
  output axi_b_t  b_o
);

  localparam int IDX_W = $clog2(`SOC_SRAM_WORDS);
  localparam int LAT   = `SOC_SRAM_LAT;
  localparam int NBYTE = `SOC_BEAT_W / 8;

  beat_t            mem [`SOC_SRAM_WORDS];
  beat_t            rd_pipe [LAT];
  logic [LAT-1:0]   rv_pipe;
  logic [19:0]      lfsr;
  logic             rd_stall;
  logic             wr_stall;
  logic             ar_fire;
  logic             wr_fire;
  logic [IDX_W-1:0] ar_idx;
  logic [IDX_W-1:0] aw_idx;
  logic             bvalid_q;

  // x^20 + x^17 + 1, free running
  always_ff @(posedge clk)
  begin
    if (rst)
      lfsr <= 20'd1;
    else
      lfsr <= {lfsr[18:0], lfsr[19] ^ lfsr[16]};
  end

  // roughly one cycle in four stalls on each path
  assign rd_stall = (`SOC_SRAM_STALL != 0) && lfsr[3] && lfsr[0];
  assign wr_stall = (`SOC_SRAM_STALL != 0) && lfsr[7] && lfsr[2];

  assign ar_ready_o = !rd_stall;
  // aw and w only go in as a pair
  assign aw_ready_o = !wr_stall && w_i.valid;
  assign w_ready_o  = !wr_stall && aw_i.valid;

  assign ar_fire = ar_i.valid && ar_ready_o;
  assign wr_fire = aw_i.valid && w_i.valid && !wr_stall;

  // beat index, bits 2:0 select within the beat
  assign ar_idx = ar_i.addr[IDX_W+2:3];
  assign aw_idx = aw_i.addr[IDX_W+2:3];

  // byte-lane write through the byte view
  always_ff @(posedge clk)
  begin
    if (wr_fire)
    begin
      for (int i = 0; i < NBYTE; i++)
      begin
        if (w_i.strb[i])
          mem[aw_idx].b[i] <= w_i.data.b[i];
      end
    end
  end

  // data stages load every cycle, rv_pipe says which one is live
  always_ff @(posedge clk)
  begin
    rd_pipe[0] <= mem[ar_idx];
    for (int i = 1; i < LAT; i++)
    begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      rv_pipe <= '0;
    else
    begin
      rv_pipe[0] <= ar_fire;
      for (int i = 1; i < LAT; i++)
      begin
        rv_pipe[i] <= rv_pipe[i-1];
      end
    end
  end

  // b one cycle after the write handshake
  always_ff @(posedge clk)
  begin
    if (rst)
      bvalid_q <= 1'b0;
    else
      bvalid_q <= wr_fire;
  end

  // responses are always OKAY
  always_comb
  begin
    r_o.data  = rd_pipe[LAT-1];
    r_o.resp  = 2'b00;
    r_o.valid = rv_pipe[LAT-1];
    b_o.resp  = 2'b00;
    b_o.valid = bvalid_q;
  end

  // single-beat writes, so w is last and always paired with aw
  a_w_with_aw: assert property (@(posedge clk) disable iff (rst)
    w_i.valid |-> aw_i.valid && w_i.last);

  // requester alignment rule has to survive the arbiter
  a_addr_align: assert property (@(posedge clk) disable iff (rst)
    (ar_i.valid |-> (ar_i.addr[2:0] & ((3'd1 << ar_i.size) - 3'd1)) == 3'd0) and
    (aw_i.valid |-> (aw_i.addr[2:0] & ((3'd1 << aw_i.size) - 3'd1)) == 3'd0));

endmodule

/* rtl/clint_timer.sv */
`timescale 1ns/1ps
`include "soc_bus_cfg.svh"

module clint_timer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rd_i,
  input  logic                   hi_i,
  output logic [`SOC_DATA_W-1:0] data_o,
  output logic                   valid_o
);

  // machine time, 64 bits, one tick per clock
  logic [2*`SOC_DATA_W-1:0] mtime;

  always_ff @(posedge clk)
  begin
    if (rst)
      mtime <= '0;
    else
      mtime <= mtime + 1'b1;
  end

  // valid follows the read strobe by one cycle
  always_ff @(posedge clk)
  begin
    if (rst)
      valid_o <= 1'b0;
    else
      valid_o <= rd_i;
  end

  // half select sampled with the strobe
  // the two halves are not snapshotted together
  always_ff @(posedge clk)
  begin
    if (rd_i)
    begin
      if (hi_i)
        data_o <= mtime[2*`SOC_DATA_W-1:`SOC_DATA_W];
      else
        data_o <= mtime[`SOC_DATA_W-1:0];
    end
  end

endmodule

/* rtl/soc_bus_pkg.sv */
`include "soc_bus_cfg.svh"

package soc_bus_pkg;

  // one bus beat
  // read path picks a 32-bit word, sram writes it byte by byte
  typedef union packed {
    logic [`SOC_BEAT_W/`SOC_DATA_W-1:0][`SOC_DATA_W-1:0] w;
    logic [`SOC_BEAT_W/8-1:0][7:0]                        b;
  } beat_t;

  // fetch request, level held until the response pulse
  typedef struct packed {
    logic [`SOC_ADDR_W-1:0] addr;
    logic                   valid;
  } rd_req_t;

  // load request, strobe 01/03/0f for byte/half/word
  typedef struct packed {
    rd_req_t    rd;
    logic [7:0] strb;
  } ld_req_t;

  typedef struct packed {
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_DATA_W-1:0] data;
    logic [7:0]             strb;
    logic                   valid;
  } st_req_t;

  // read data back to a requester, valid is a one-cycle pulse
  typedef struct packed {
    logic [`SOC_DATA_W-1:0] data;
    logic                   valid;
  } rd_resp_t;

  // ar and aw share a layout
  typedef struct packed {
    logic [`SOC_ADDR_W-1:0] addr;
    logic [2:0]             size;
    logic                   valid;
  } axi_ax_t;

  typedef axi_ax_t axi_ar_t;
  typedef axi_ax_t axi_aw_t;

  typedef struct packed {
    beat_t      data;
    logic [7:0] strb;
    logic       last;
    logic       valid;
  } axi_w_t;

  typedef struct packed {
    beat_t      data;
    logic [1:0] resp;
    logic       valid;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
    logic       valid;
  } axi_b_t;

  typedef struct packed {
    logic [7:0] ch;
    logic       valid;
  } console_t;

endpackage

/* rtl/soc_bus_cfg.svh */
`ifndef SOC_BUS_CFG_SVH
`define SOC_BUS_CFG_SVH

// requester side is 32 bits wide, the bus beat is 64
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_BEAT_W 64

// mtime low and high halves, answered by the local timer
`define SOC_RTC_ADDR    32'ha000_0048
`define SOC_RTC_ADDR_UP 32'ha000_004c

// console byte port, store only
`define SOC_SERIAL_ADDR 32'ha000_03f8

// sram depth in 64-bit beats
`define SOC_SRAM_WORDS 256
// cycles from ar handshake to r valid
`define SOC_SRAM_LAT 2
// 1 lets the lfsr drop arready and awready
`define SOC_SRAM_STALL 1

`endif
